// ==== flist.f ====
+incdir+verilog
verilog/approx_mul_pkg.sv
verilog/lower_or_adder.sv
verilog/recursive_mul4.sv
verilog/recursive_mul8.sv
verilog/mul_datapath.sv
verilog/mul_config_regs.sv
verilog/approx_mul_top.sv
tests/approx_mul_assertions.sv
tests/approx_mul_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and checks the simulation output for the pass message.
verilator --binary --timing --assert -Wno-fatal --top-module approx_mul_tb -f flist.f \
    && ./obj_dir/Vapprox_mul_tb +verilator+error+limit+1000 | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/approx_mul_assertions.sv ====
`include "approx_mul_macros.svh"

module approx_mul_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic [`AM_OPERAND_W-1:0]  a,
    input logic [`AM_OPERAND_W-1:0]  b,
    input logic                      in_valid,
    input logic                      cfg_we,
    input logic                      cfg_re,
    input approx_mul_pkg::cfg_addr_t cfg_addr,
    input logic [`AM_CFG_DATA_W-1:0] cfg_wdata,
    input approx_mul_pkg::product_t  p,
    input logic                      out_valid,
    input logic [`AM_CFG_DATA_W-1:0] cfg_rdata,
    input logic                      cfg_rvalid,
    input logic                      exact_mode
);
    int fail_count = 0;

    logic                      seen_rst = 1'b0;
    logic                      rst_d1 = 1'b0;
    logic                      mode_shadow;  // Mode as written over the config port.
    logic [`AM_CFG_DATA_W-1:0] count_shadow;
    logic [`AM_CFG_DATA_W-1:0] rdata_exp;
    logic [`AM_OPERAND_W-1:0]  a_d1;
    logic [`AM_OPERAND_W-1:0]  a_d2;
    logic [`AM_OPERAND_W-1:0]  b_d1;
    logic [`AM_OPERAND_W-1:0]  b_d2;
    logic                      m_d1;
    logic                      m_d2;
    logic                      v_d1;
    logic                      v_d2;
    logic                      re_d1;
    approx_mul_pkg::product_t  p_exp;
    approx_mul_pkg::product_t  p_true;

    // The low k bits are ORed and give no carry to the exact upper part.
    function automatic int or_add(input int x, input int y, input int k, input logic exact);
        int mask;
        mask = (1 << k) - 1;
        if (exact) begin
            return x + y;
        end
        return ((x & ~mask) + (y & ~mask)) | ((x | y) & mask);
    endfunction

    function automatic int approx_mul4(input int x, input int y, input logic exact);
        int s;
        s = or_add((x >> 1) * (y & 1), (x & 1) * (y >> 1), 0, exact);
        s = or_add(((x >> 1) * (y >> 1)) << 1, s, 3, exact);
        return (s << 1) | (x & y & 1);
    endfunction

    function automatic int approx_mul8(input int x, input int y, input logic exact);
        int hh;
        int ll;
        int s;
        hh = approx_mul4(x >> 4, y >> 4, exact);
        ll = approx_mul4(x & 15, y & 15, exact);
        s  = or_add((x >> 4) * (y & 15), (x & 15) * (y >> 4), 0, exact);
        s  = or_add((hh << 4) | (ll >> 4), s, 3, exact);
        return ((s << 4) | (ll & 15)) & 16'hFFFF;
    endfunction

    assign p_exp  = 16'(approx_mul8(int'(a_d2), int'(b_d2), m_d2));
    assign p_true = 16'(a_d2) * 16'(b_d2);

    always @(posedge clk) begin
        seen_rst <= seen_rst | rst;
        rst_d1   <= rst;
        a_d1     <= a;
        a_d2     <= a_d1;
        b_d1     <= b;
        b_d2     <= b_d1;
        m_d1     <= mode_shadow;  // The mode in effect when the pair is sampled.
        m_d2     <= m_d1;
        if (cfg_re) begin
            rdata_exp <= (cfg_addr == approx_mul_pkg::CFG_CTRL)
                       ? {{(`AM_CFG_DATA_W-1){1'b0}}, mode_shadow} : count_shadow;
        end
        if (rst) begin
            v_d1         <= 1'b0;
            v_d2         <= 1'b0;
            re_d1        <= 1'b0;
            mode_shadow  <= 1'b0;
            count_shadow <= '0;
        end else begin
            v_d1  <= in_valid;
            v_d2  <= v_d1;
            re_d1 <= cfg_re;
            if (cfg_we && cfg_addr == approx_mul_pkg::CFG_CTRL) begin
                mode_shadow <= cfg_wdata[0];
            end
            if (out_valid) begin
                count_shadow <= count_shadow + 1'b1;
            end
        end
    end

    ap_reset_state: assert property (@(posedge clk)
        rst_d1 |-> !exact_mode && !out_valid && !cfg_rvalid)
        else begin
            fail_count = fail_count + 1;
            $error("Outputs or mode were not cleared by reset");
        end

    ap_out_valid: assert property (@(posedge clk) seen_rst |-> out_valid == v_d2)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch in out_valid: expected %0b, actual %0b",
                   $sampled(v_d2), $sampled(out_valid));
        end

    ap_product: assert property (@(posedge clk) v_d2 |-> p == p_exp)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch in product: expected %0d, actual %0d", $sampled(p_exp), $sampled(p));
        end

    ap_exact: assert property (@(posedge clk) v_d2 && m_d2 |-> p == p_true)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch in exact product: expected %0d, actual %0d",
                   $sampled(p_true), $sampled(p));
        end

    ap_bound: assert property (@(posedge clk) v_d2 |-> p <= p_true)
        else begin
            fail_count = fail_count + 1;
            $error("Product %0d is larger than the true product %0d",
                   $sampled(p), $sampled(p_true));
        end

    ap_rvalid: assert property (@(posedge clk) seen_rst |-> cfg_rvalid == re_d1)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch in cfg_rvalid: expected %0b, actual %0b",
                   $sampled(re_d1), $sampled(cfg_rvalid));
        end

    ap_rdata: assert property (@(posedge clk) re_d1 |-> cfg_rdata == rdata_exp)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch in read data: expected %0d, actual %0d",
                   $sampled(rdata_exp), $sampled(cfg_rdata));
        end

endmodule

bind approx_mul_top approx_mul_assertions i_assertions (.*);

// ==== tests/approx_mul_tb.sv ====
`include "approx_mul_macros.svh"

module approx_mul_tb;
    localparam int RESET_CYCLES = 8;
    // Reset, exact, approximate, corners, mode stream and counter tests plus a margin.
    localparam int LIMIT = 20 + 215 + 215 + 260 + 130 + 20 + 200;

    logic                      clk;
    logic                      rst;
    logic [`AM_OPERAND_W-1:0]  a;
    logic [`AM_OPERAND_W-1:0]  b;
    logic                      in_valid;
    logic                      cfg_we;
    logic                      cfg_re;
    approx_mul_pkg::cfg_addr_t cfg_addr;
    logic [`AM_CFG_DATA_W-1:0] cfg_wdata;
    approx_mul_pkg::product_t  p;
    logic                      out_valid;
    logic [`AM_CFG_DATA_W-1:0] cfg_rdata;
    logic                      cfg_rvalid;

    logic [15:0] lfsr_state;
    logic [7:0]  corners [11];
    int          cycles;
    int          tests_passed;
    int          tests_failed;
    int          fails_seen;

    approx_mul_top i_dut (.*);

    always #20 clk = ~clk;

    // Galois LFSR, one step per bit taken.
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic drive_cycle(input logic v, input logic [7:0] x, input logic [7:0] y,
                               input logic we, input logic re,
                               input approx_mul_pkg::cfg_addr_t addr, input logic [15:0] wd);
        @(posedge clk);
        in_valid  <= v;
        a         <= x;
        b         <= y;
        cfg_we    <= we;
        cfg_re    <= re;
        cfg_addr  <= addr;
        cfg_wdata <= wd;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, approx_mul_pkg::CFG_CTRL, '0);
    endtask

    task automatic send_pair(input logic [7:0] x, input logic [7:0] y);
        drive_cycle(1'b1, x, y, 1'b0, 1'b0, approx_mul_pkg::CFG_CTRL, '0);
    endtask

    task automatic send_random();
        logic [7:0] x;
        logic [7:0] y;
        x = rand_bits(8);
        y = rand_bits(8);
        send_pair(x, y);
    endtask

    task automatic write_cfg(input approx_mul_pkg::cfg_addr_t addr, input logic [15:0] wd);
        drive_cycle(1'b0, '0, '0, 1'b1, 1'b0, addr, wd);
    endtask

    task automatic read_cfg(input approx_mul_pkg::cfg_addr_t addr);
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, addr, '0);
        idle(1);
        @(negedge clk);
        while (!cfg_rvalid) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        int errors;
        errors     = i_dut.i_assertions.fail_count - fails_seen;
        fails_seen = i_dut.i_assertions.fail_count;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d assertion failures", name, errors);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [7:0] x;
        logic [7:0] y;
        clk          = 1'b0;
        rst          = 1'b1;
        a            = '0;
        b            = '0;
        in_valid     = 1'b0;
        cfg_we       = 1'b0;
        cfg_re       = 1'b0;
        cfg_addr     = approx_mul_pkg::CFG_CTRL;
        cfg_wdata    = '0;
        lfsr_state   = 16'd60054;
        cycles       = 0;
        tests_passed = 0;
        tests_failed = 0;
        fails_seen   = 0;
        corners = '{8'd0, 8'd1, 8'd15, 8'd16, 8'd255, 8'd2, 8'd4, 8'd8, 8'd32, 8'd64, 8'd128};

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        read_cfg(approx_mul_pkg::CFG_CTRL);
        read_cfg(approx_mul_pkg::CFG_COUNT);
        idle(2);
        report_test("reset");

        write_cfg(approx_mul_pkg::CFG_CTRL, 16'd1);
        repeat (200) send_random();
        idle(4);
        report_test("exact_mode");

        write_cfg(approx_mul_pkg::CFG_CTRL, 16'd0);
        repeat (200) send_random();
        idle(4);
        report_test("approx_mode");

        for (int m = 0; m < 2; m++) begin
            write_cfg(approx_mul_pkg::CFG_CTRL, 16'(m));
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    send_pair(corners[i], corners[j]);
                end
            end
        end
        idle(4);
        report_test("corners");

        // A mode write lands in the same cycle as an operand pair now and then.
        for (int i = 0; i < 120; i++) begin
            x = rand_bits(8);
            y = rand_bits(8);
            if (i % 8 == 3) begin
                drive_cycle(1'b1, x, y, 1'b1, 1'b0, approx_mul_pkg::CFG_CTRL,
                            {15'b0, rand_bits(1) == 8'd1});
            end else begin
                send_pair(x, y);
            end
        end
        idle(4);
        report_test("mode_stream");

        read_cfg(approx_mul_pkg::CFG_COUNT);
        write_cfg(approx_mul_pkg::CFG_COUNT, 16'h1234);
        read_cfg(approx_mul_pkg::CFG_COUNT);
        drive_cycle(1'b0, '0, '0, 1'b1, 1'b1, approx_mul_pkg::CFG_CTRL, 16'd1);
        read_cfg(approx_mul_pkg::CFG_CTRL);
        idle(2);
        report_test("counter");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/approx_mul_macros.svh ====
`ifndef APPROX_MUL_MACROS_SVH
`define APPROX_MUL_MACROS_SVH

// Operand width of the multiplier.
`define AM_OPERAND_W 8

// Full product width, twice the operand width.
`define AM_PRODUCT_W 16

// Width of the configuration read and write data.
`define AM_CFG_DATA_W 16

`endif

// ==== verilog/approx_mul_pkg.sv ====
`include "approx_mul_macros.svh"

package approx_mul_pkg;

    // Unsigned product of two operands.
    typedef logic [`AM_PRODUCT_W-1:0] product_t;

    // Configuration register map.
    typedef enum logic [0:0] {
        CFG_CTRL  = 1'b0,  // Bit 0 is the exact mode.
        CFG_COUNT = 1'b1   // Products delivered, read-only.
    } cfg_addr_t;

endpackage

// ==== verilog/approx_mul_top.sv ====
`include "approx_mul_macros.svh"

module approx_mul_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AM_OPERAND_W-1:0]  a,
    input  logic [`AM_OPERAND_W-1:0]  b,
    input  logic                      in_valid,
    input  logic                      cfg_we,
    input  logic                      cfg_re,
    input  approx_mul_pkg::cfg_addr_t cfg_addr,
    input  logic [`AM_CFG_DATA_W-1:0] cfg_wdata,
    output approx_mul_pkg::product_t  p,
    output logic                      out_valid,
    output logic [`AM_CFG_DATA_W-1:0] cfg_rdata,
    output logic                      cfg_rvalid
);
    logic exact_mode;

    mul_config_regs i_cfg (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_re     (cfg_re),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .out_valid  (out_valid),   // Counts delivered products.
        .exact_mode (exact_mode),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid)
    );

    mul_datapath i_datapath (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .b          (b),
        .in_valid   (in_valid),
        .exact_mode (exact_mode),
        .p          (p),
        .out_valid  (out_valid)
    );

endmodule

// ==== verilog/lower_or_adder.sv ====
module lower_or_adder #(
    parameter int WIDTH       = 8,
    parameter int APPROX_BITS = 3
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             exact,
    output logic [WIDTH:0]   sum
);
    // Bits below this mask are ORed in approximate mode.
    localparam logic [WIDTH-1:0] LOW_MASK = WIDTH'((1 << APPROX_BITS) - 1);

    logic [WIDTH:0]   exact_sum;
    logic [WIDTH:0]   upper_sum;
    logic [WIDTH-1:0] lower_or;

    assign exact_sum = {1'b0, x} + {1'b0, y};

    // The masked upper parts add with zeros below, so no carry comes up from the low bits.
    assign upper_sum = {1'b0, x & ~LOW_MASK} + {1'b0, y & ~LOW_MASK};
    assign lower_or  = (x | y) & LOW_MASK;

    assign sum = exact ? exact_sum : (upper_sum | {1'b0, lower_or});

endmodule

// ==== verilog/mul_config_regs.sv ====
`include "approx_mul_macros.svh"

module mul_config_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  logic                      cfg_re,
    input  approx_mul_pkg::cfg_addr_t cfg_addr,
    input  logic [`AM_CFG_DATA_W-1:0] cfg_wdata,
    input  logic                      out_valid,
    output logic                      exact_mode,
    output logic [`AM_CFG_DATA_W-1:0] cfg_rdata,
    output logic                      cfg_rvalid
);
    logic [`AM_CFG_DATA_W-1:0] product_count;

    // Only the control register is writable.
    always_ff @(posedge clk) begin
        if (rst) begin
            exact_mode <= 1'b0;
        end else if (cfg_we && cfg_addr == approx_mul_pkg::CFG_CTRL) begin
            exact_mode <= cfg_wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            product_count <= '0;
        end else if (out_valid) begin
            product_count <= product_count + 1'b1;  // Wraps at full width.
        end
    end

    // Read data is taken from the registers before any write in the same cycle.
    always_ff @(posedge clk) begin
        if (cfg_re) begin
            case (cfg_addr)
                approx_mul_pkg::CFG_CTRL:  cfg_rdata <= {{(`AM_CFG_DATA_W-1){1'b0}}, exact_mode};
                approx_mul_pkg::CFG_COUNT: cfg_rdata <= product_count;
                default:                   cfg_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= cfg_re;
        end
    end

endmodule

// ==== verilog/mul_datapath.sv ====
`include "approx_mul_macros.svh"

module mul_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`AM_OPERAND_W-1:0] a,
    input  logic [`AM_OPERAND_W-1:0] b,
    input  logic                     in_valid,
    input  logic                     exact_mode,
    output approx_mul_pkg::product_t p,
    output logic                     out_valid
);
    logic [`AM_OPERAND_W-1:0] a_q;
    logic [`AM_OPERAND_W-1:0] b_q;
    logic                     exact_q;
    logic                     valid_q;
    approx_mul_pkg::product_t product;

    // The mode is captured with the operands so a later write cannot affect this pair.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q     <= a;
            b_q     <= b;
            exact_q <= exact_mode;
        end
    end

    recursive_mul8 #(.APPROX_BITS(3)) i_mul (
        .a     (a_q),
        .b     (b_q),
        .exact (exact_q),
        .p     (product)
    );

    always_ff @(posedge clk) begin
        if (valid_q) begin
            p <= product;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out_valid <= valid_q;  // One pulse per accepted pair.
        end
    end

endmodule

// ==== verilog/recursive_mul4.sv ====
module recursive_mul4 #(
    parameter int APPROX_BITS = 3
) (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       exact,
    output logic [7:0] p
);
    // Split each operand into a 3-bit high part and a 1-bit low part.
    logic [2:0] a_h;
    logic [2:0] b_h;
    logic       a_l;
    logic       b_l;

    logic [5:0] p_hh;
    logic [2:0] p_hl;
    logic [2:0] p_lh;
    logic       p_ll;

    logic [3:0] cross_sum;
    logic [6:0] operand1;
    logic [6:0] operand2;
    logic [7:0] out;

    assign a_h = a[3:1];
    assign b_h = b[3:1];
    assign a_l = a[0];
    assign b_l = b[0];

    assign p_hh = a_h * b_h;
    assign p_hl = a_h & {3{b_l}};  // A one-bit factor reduces to a gate.
    assign p_lh = b_h & {3{a_l}};
    assign p_ll = a_l & b_l;

    lower_or_adder #(
        .WIDTH       (3),
        .APPROX_BITS (0)
    ) i_cross_adder (
        .x     (p_hl),
        .y     (p_lh),
        .exact (exact),
        .sum   (cross_sum)
    );

    // High product sits one bit up, the cross sum lines up with bit 0 of out.
    assign operand1 = {p_hh, 1'b0};
    assign operand2 = {3'b000, cross_sum};

    lower_or_adder #(
        .WIDTH       (7),
        .APPROX_BITS (APPROX_BITS)
    ) i_final_adder (
        .x     (operand1),
        .y     (operand2),
        .exact (exact),
        .sum   (out)
    );

    assign p = {out[6:0], p_ll};  // The sum cannot reach bit 7 of out.

endmodule

// ==== verilog/recursive_mul8.sv ====
`include "approx_mul_macros.svh"

module recursive_mul8 #(
    parameter int APPROX_BITS = 3
) (
    input  logic [`AM_OPERAND_W-1:0] a,
    input  logic [`AM_OPERAND_W-1:0] b,
    input  logic                     exact,
    output approx_mul_pkg::product_t p
);
    logic [3:0] a_h;
    logic [3:0] b_h;
    logic [3:0] a_l;
    logic [3:0] b_l;

    logic [7:0] p_hh;
    logic [7:0] p_hl;
    logic [7:0] p_lh;
    logic [7:0] p_ll;

    logic [8:0]  cross_sum;
    logic [11:0] operand1;
    logic [11:0] operand2;
    logic [12:0] out;

    assign a_h = a[7:4];
    assign b_h = b[7:4];
    assign a_l = a[3:0];
    assign b_l = b[3:0];

    recursive_mul4 #(.APPROX_BITS(APPROX_BITS)) i_mul_hh (
        .a     (a_h),
        .b     (b_h),
        .exact (exact),
        .p     (p_hh)
    );

    recursive_mul4 #(.APPROX_BITS(APPROX_BITS)) i_mul_ll (
        .a     (a_l),
        .b     (b_l),
        .exact (exact),
        .p     (p_ll)
    );

    // Cross terms stay exact.
    assign p_hl = a_h * b_l;
    assign p_lh = a_l * b_h;

    lower_or_adder #(
        .WIDTH       (8),
        .APPROX_BITS (0)
    ) i_cross_adder (
        .x     (p_hl),
        .y     (p_lh),
        .exact (exact),
        .sum   (cross_sum)
    );

    // Everything here is aligned to product bit 4.
    assign operand1 = {p_hh, p_ll[7:4]};
    assign operand2 = {3'b000, cross_sum};

    lower_or_adder #(
        .WIDTH       (12),
        .APPROX_BITS (APPROX_BITS)
    ) i_final_adder (
        .x     (operand1),
        .y     (operand2),
        .exact (exact),
        .sum   (out)
    );

    assign p = {out[11:0], p_ll[3:0]};

endmodule
